// ==== verilog/disp_pkg.sv ====
`default_nettype none

package disp_pkg;

    // 640x480 at 60 Hz, 25.175 MHz pixel clock
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam int COORD_W = 11;   // holds 0..H_TOTAL-1

    // frame and depth buffers share one geometry
    localparam int FB_W       = 160;
    localparam int FB_H       = 120;
    localparam int BUF_DEPTH  = FB_W * FB_H;
    localparam int BUF_ADDR_W = $clog2(BUF_DEPTH);

    // counters to pins: ram read, then palette and output register
    localparam int SCAN_LAT = 2;

endpackage

`default_nettype wire

// ==== verilog/px_pkg.sv ====
`default_nettype none

package px_pkg;

    typedef logic [3:0]  color_idx_t;
    typedef logic [11:0] depth_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    localparam color_idx_t FB_CLEAR = 4'd0;
    localparam depth_t     DB_CLEAR = 12'd4095;   // farthest depth

    // fixed colour lookup, index 0 is the cleared colour
    localparam rgb_t PALETTE [16] = '{
        12'h000, 12'h125, 12'h725, 12'h085,
        12'ha53, 12'h554, 12'hccc, 12'hffe,
        12'hf04, 12'hfa0, 12'hfe2, 12'h0e3,
        12'h2af, 12'h879, 12'hf7a, 12'hfca
    };

    localparam rgb_t BG_COLOR = 12'h137;

endpackage

`default_nettype wire

// ==== verilog/buf_port_if.sv ====
`default_nettype none

interface buf_port_if
    import px_pkg::*;
#(
    parameter int ADDR_W = 15
);

    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    color_idx_t        wr_idx;
    depth_t            wr_depth;
    logic              gnt;       // access happens in this cycle
    color_idx_t        rd_idx;    // valid one cycle after gnt
    depth_t            rd_depth;

    modport requester (
        output req, we, addr, wr_idx, wr_depth,
        input  gnt, rd_idx, rd_depth
    );

    modport arbiter (
        input  req, we, addr, wr_idx, wr_depth,
        output gnt, rd_idx, rd_depth
    );

endinterface

`default_nettype wire

// ==== verilog/display_timing.sv ====
`default_nettype none

module display_timing
    import disp_pkg::*;
(
    input  wire logic               clk_pix,
    input  wire logic               i_arst_n,
    output logic      [COORD_W-1:0] o_sx,
    output logic      [COORD_W-1:0] o_sy,
    output logic                    o_hsync,
    output logic                    o_vsync,
    output logic                    o_de,
    output logic                    o_frame
);

    logic [COORD_W-1:0] sx;
    logic [COORD_W-1:0] sy;
    logic               line_end;

    assign line_end = (sx == COORD_W'(H_TOTAL - 1));

    always_ff @(posedge clk_pix or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            if (sy == COORD_W'(V_TOTAL - 1)) begin
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        o_sx    = sx;
        o_sy    = sy;
        // sync pulses are active low
        o_hsync = !((sx >= H_ACTIVE + H_FRONT) && (sx < H_ACTIVE + H_FRONT + H_SYNC));
        o_vsync = !((sy >= V_ACTIVE + V_FRONT) && (sy < V_ACTIVE + V_FRONT + V_SYNC));
        o_de    = (sx < H_ACTIVE) && (sy < V_ACTIVE);
        o_frame = (sx == '0) && (sy == '0);
    end

    // the line counter wraps at H_TOTAL and never shows it
    a_sx_wrap: assert property (@(posedge clk_pix) disable iff (!i_arst_n)
        o_sx < H_TOTAL)
        else $error("display_timing: horizontal counter left its range");

endmodule

`default_nettype wire

// ==== verilog/pixel_buffer.sv ====
`default_nettype none

module pixel_buffer #(
    parameter type word_t = logic [7:0],
    parameter int  DEPTH  = 256
) (
    input  wire logic                     clk_pix,
    input  wire logic                     i_we,
    input  wire logic [$clog2(DEPTH)-1:0] i_addr,
    input  wire word_t                    i_wdata,
    output word_t                         o_rdata
);

    word_t mem [DEPTH];

    // read-first, old contents come out on a write cycle
    always_ff @(posedge clk_pix) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/buffer_arbiter.sv ====
`default_nettype none

module buffer_arbiter
    import disp_pkg::*;
    import px_pkg::*;
(
    input  wire logic                  clk_pix,
    input  wire logic                  i_arst_n,
    input  wire logic                  i_wr_stb,
    input  wire logic [BUF_ADDR_W-1:0] i_wr_addr,
    input  wire color_idx_t            i_wr_idx,
    input  wire depth_t                i_wr_depth,
    input  wire logic                  i_ready,
    output logic                       o_wr_busy,
    buf_port_if.arbiter                scan_port,
    buf_port_if.arbiter                clr_port,
    output logic                       o_fb_we,
    output logic                       o_db_we,
    output logic      [BUF_ADDR_W-1:0] o_addr,
    output color_idx_t                 o_fb_wdata,
    output depth_t                     o_db_wdata,
    input  wire color_idx_t            i_fb_rdata,
    input  wire depth_t                i_db_rdata
);

    logic                  held_vld;
    logic [BUF_ADDR_W-1:0] held_addr;
    color_idx_t            held_idx;
    depth_t                held_depth;
    logic                  wr_gnt;
    logic                  wr_load;

    assign wr_load = i_wr_stb && i_ready;   // writes during a clear are dropped

    // scan-out first, then clear, then the held raster write
    assign scan_port.gnt = scan_port.req;
    assign clr_port.gnt  = clr_port.req && !scan_port.req;
    assign wr_gnt        = held_vld && !scan_port.req && !clr_port.req;

    always_comb begin
        if (scan_port.req) begin
            o_addr     = scan_port.addr;
            o_fb_we    = scan_port.we;
            o_db_we    = scan_port.we;
            o_fb_wdata = scan_port.wr_idx;
            o_db_wdata = scan_port.wr_depth;
        end else if (clr_port.req) begin
            o_addr     = clr_port.addr;
            o_fb_we    = clr_port.we;
            o_db_we    = clr_port.we;
            o_fb_wdata = clr_port.wr_idx;
            o_db_wdata = clr_port.wr_depth;
        end else begin
            o_addr     = held_addr;
            o_fb_we    = wr_gnt;
            o_db_we    = wr_gnt;
            o_fb_wdata = held_idx;
            o_db_wdata = held_depth;
        end
    end

    // read data fans back to every requester
    assign scan_port.rd_idx   = i_fb_rdata;
    assign scan_port.rd_depth = i_db_rdata;
    assign clr_port.rd_idx    = i_fb_rdata;
    assign clr_port.rd_depth  = i_db_rdata;

    always_ff @(posedge clk_pix or negedge i_arst_n) begin
        if (!i_arst_n) begin
            held_vld <= 1'b0;
        end else if (wr_load) begin
            held_vld <= 1'b1;
        end else if (wr_gnt || !i_ready) begin
            held_vld <= 1'b0;   // written, or wiped by a starting clear
        end
    end

    always_ff @(posedge clk_pix) begin
        if (wr_load) begin
            held_addr  <= i_wr_addr;
            held_idx   <= i_wr_idx;
            held_depth <= i_wr_depth;
        end
    end

    assign o_wr_busy = held_vld;

    // scan-out only reads, so memory writes come from clear or the held write
    a_scan_no_write: assert property (@(posedge clk_pix) disable iff (!i_arst_n)
        (o_fb_we || o_db_we) |-> (clr_port.gnt || wr_gnt))
        else $error("buffer_arbiter: memory write during a scan-out grant");

    a_no_stb_busy: assert property (@(posedge clk_pix) disable iff (!i_arst_n)
        i_wr_stb |-> !o_wr_busy)
        else $error("buffer_arbiter: write strobe while the holding register is full");

endmodule

`default_nettype wire

// ==== verilog/buffer_clear.sv ====
`default_nettype none

module buffer_clear
    import disp_pkg::*;
    import px_pkg::*;
(
    input  wire logic   clk_pix,
    input  wire logic   i_arst_n,
    input  wire logic   i_start,
    buf_port_if.requester clr_port,
    output logic        o_ready
);

    logic                  busy;
    logic [BUF_ADDR_W-1:0] addr;
    logic                  last;

    assign last = (addr == BUF_ADDR_W'(BUF_DEPTH - 1));

    // a sweep also runs straight out of reset
    always_ff @(posedge clk_pix or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy <= 1'b1;
            addr <= '0;
        end else if (i_start) begin
            busy <= 1'b1;
            addr <= '0;
        end else if (busy && clr_port.gnt) begin
            if (last) begin
                busy <= 1'b0;
                addr <= '0;
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

    assign clr_port.req      = busy;
    assign clr_port.we       = 1'b1;
    assign clr_port.addr     = addr;
    assign clr_port.wr_idx   = FB_CLEAR;
    assign clr_port.wr_depth = DB_CLEAR;

    assign o_ready = !busy;

endmodule

`default_nettype wire

// ==== verilog/scanout.sv ====
`default_nettype none

module scanout
    import disp_pkg::*;
    import px_pkg::*;
(
    input  wire logic               clk_pix,
    input  wire logic               i_arst_n,
    input  wire logic [COORD_W-1:0] i_sx,
    input  wire logic [COORD_W-1:0] i_sy,
    input  wire logic               i_hsync,
    input  wire logic               i_vsync,
    input  wire logic               i_de,
    input  wire logic               i_frame,
    buf_port_if.requester           scan_port,
    output rgb_t                    o_rgb,
    output logic                    o_hsync,
    output logic                    o_vsync,
    output logic                    o_de
);

    logic                  in_fb;
    logic                  in_db;
    logic [BUF_ADDR_W-1:0] fb_addr;
    logic [BUF_ADDR_W-1:0] db_addr;
    logic [BUF_ADDR_W-1:0] fb_base;
    logic [BUF_ADDR_W-1:0] db_base;
    logic                  fb_q;
    logic                  db_q;
    logic [SCAN_LAT-1:0]   hs_pipe;
    logic [SCAN_LAT-1:0]   vs_pipe;
    logic [SCAN_LAT-1:0]   de_pipe;

    always_comb begin
        in_fb   = (i_sy < FB_H) && (i_sx < FB_W);
        in_db   = (i_sy < FB_H) && (i_sx >= FB_W) && (i_sx < 2 * FB_W);
        // frame pulse sits on pixel (0,0), so that read already uses address 0
        fb_base = i_frame ? '0 : fb_addr;
        db_base = i_frame ? '0 : db_addr;
    end

    // the two regions never overlap, one port is enough
    assign scan_port.req      = in_fb || in_db;
    assign scan_port.we       = 1'b0;
    assign scan_port.addr     = in_fb ? fb_base : db_base;
    assign scan_port.wr_idx   = '0;
    assign scan_port.wr_depth = '0;

    always_ff @(posedge clk_pix or negedge i_arst_n) begin
        if (!i_arst_n) begin
            fb_addr <= '0;
            db_addr <= '0;
        end else begin
            fb_addr <= (in_fb && scan_port.gnt) ? fb_base + 1'b1 : fb_base;
            db_addr <= (in_db && scan_port.gnt) ? db_base + 1'b1 : db_base;
        end
    end

    // region flags ride with the ram read, sync and enable with the whole path
    always_ff @(posedge clk_pix or negedge i_arst_n) begin
        if (!i_arst_n) begin
            fb_q    <= 1'b0;
            db_q    <= 1'b0;
            hs_pipe <= '1;
            vs_pipe <= '1;
            de_pipe <= '0;
        end else begin
            fb_q    <= in_fb;
            db_q    <= in_db;
            hs_pipe <= {hs_pipe[SCAN_LAT-2:0], i_hsync};
            vs_pipe <= {vs_pipe[SCAN_LAT-2:0], i_vsync};
            de_pipe <= {de_pipe[SCAN_LAT-2:0], i_de};
        end
    end

    always_ff @(posedge clk_pix or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rgb <= '0;
        end else if (fb_q) begin
            o_rgb <= PALETTE[scan_port.rd_idx];
        end else if (db_q) begin
            o_rgb <= '{red: scan_port.rd_depth[11:8], green: 4'h0, blue: 4'h0};   // red shade
        end else if (de_pipe[0]) begin
            o_rgb <= BG_COLOR;
        end else begin
            o_rgb <= '0;   // blanking
        end
    end

    assign o_hsync = hs_pipe[SCAN_LAT-1];
    assign o_vsync = vs_pipe[SCAN_LAT-1];
    assign o_de    = de_pipe[SCAN_LAT-1];

    // display reads must never be delayed by clear or raster traffic
    a_scan_wins: assert property (@(posedge clk_pix) disable iff (!i_arst_n)
        scan_port.req |-> scan_port.gnt)
        else $error("scanout: read request not granted");

endmodule

`default_nettype wire

// ==== verilog/tri_display.sv ====
`default_nettype none

module tri_display
    import disp_pkg::*;
    import px_pkg::*;
(
    input  wire logic                  clk_pix,
    input  wire logic                  i_arst_n,
    input  wire logic                  i_wr_stb,
    input  wire logic [BUF_ADDR_W-1:0] i_wr_addr,
    input  wire color_idx_t            i_wr_idx,
    input  wire depth_t                i_wr_depth,
    input  wire logic                  i_clear,
    output logic                       o_wr_busy,
    output logic                       o_ready,
    output logic      [3:0]            o_red,
    output logic      [3:0]            o_green,
    output logic      [3:0]            o_blue,
    output logic                       o_hsync,
    output logic                       o_vsync,
    output logic                       o_de
);

    logic [COORD_W-1:0]    sx;
    logic [COORD_W-1:0]    sy;
    logic                  hsync;
    logic                  vsync;
    logic                  de;
    logic                  frame;
    rgb_t                  rgb;
    logic                  fb_we;
    logic                  db_we;
    logic [BUF_ADDR_W-1:0] buf_addr;
    color_idx_t            fb_wdata;
    color_idx_t            fb_rdata;
    depth_t                db_wdata;
    depth_t                db_rdata;

    buf_port_if #(.ADDR_W(BUF_ADDR_W)) scan_port ();
    buf_port_if #(.ADDR_W(BUF_ADDR_W)) clr_port ();

    display_timing u_timing (
        .clk_pix, .i_arst_n,
        .o_sx(sx), .o_sy(sy), .o_hsync(hsync), .o_vsync(vsync), .o_de(de), .o_frame(frame)
    );

    scanout u_scanout (
        .clk_pix, .i_arst_n,
        .i_sx(sx), .i_sy(sy), .i_hsync(hsync), .i_vsync(vsync), .i_de(de), .i_frame(frame),
        .scan_port(scan_port.requester),
        .o_rgb(rgb), .o_hsync, .o_vsync, .o_de
    );

    buffer_clear u_clear (
        .clk_pix, .i_arst_n,
        .i_start(i_clear), .clr_port(clr_port.requester), .o_ready
    );

    buffer_arbiter u_arbiter (
        .clk_pix, .i_arst_n,
        .i_wr_stb, .i_wr_addr, .i_wr_idx, .i_wr_depth,
        .i_ready(o_ready), .o_wr_busy,
        .scan_port(scan_port.arbiter), .clr_port(clr_port.arbiter),
        .o_fb_we(fb_we), .o_db_we(db_we), .o_addr(buf_addr),
        .o_fb_wdata(fb_wdata), .o_db_wdata(db_wdata),
        .i_fb_rdata(fb_rdata), .i_db_rdata(db_rdata)
    );

    pixel_buffer #(.word_t(color_idx_t), .DEPTH(BUF_DEPTH)) frame_buf (
        .clk_pix, .i_we(fb_we), .i_addr(buf_addr), .i_wdata(fb_wdata), .o_rdata(fb_rdata)
    );

    pixel_buffer #(.word_t(depth_t), .DEPTH(BUF_DEPTH)) depth_buf (
        .clk_pix, .i_we(db_we), .i_addr(buf_addr), .i_wdata(db_wdata), .o_rdata(db_rdata)
    );

    assign o_red   = rgb.red;
    assign o_green = rgb.green;
    assign o_blue  = rgb.blue;

endmodule

`default_nettype wire

// ==== tb/tb_tri_display.sv ====
`default_nettype none

module tb_tri_display
    import disp_pkg::*;
    import px_pkg::*;
();

    localparam int FRAME_CYC    = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_CYC = 8 * FRAME_CYC + 4 * BUF_DEPTH;   // six frames used
    localparam int N_WRITES     = 40;

    logic                  clk_pix;
    logic                  arst_n;
    logic                  wr_stb;
    logic [BUF_ADDR_W-1:0] wr_addr;
    color_idx_t            wr_idx;
    depth_t                wr_depth;
    logic                  clear;
    logic                  wr_busy;
    logic                  ready;
    logic [3:0]            red;
    logic [3:0]            green;
    logic [3:0]            blue;
    logic                  hsync;
    logic                  vsync;
    logic                  de;

    color_idx_t  shadow_fb [BUF_DEPTH];
    depth_t      shadow_db [BUF_DEPTH];
    logic [31:0] lfsr_state = 32'h7fae_a79c;
    logic        check_en;
    int          pos_col;
    int          pos_row;
    rgb_t        exp_rgb;
    int          de_run;
    int          hs_run;
    int          vs_run;
    int          line_cnt;
    logic        de_prev;
    int          checked_px;
    int          pix_errs;
    int          sync_errs;
    int          misc_errs;

    tri_display dut_i (
        .clk_pix(clk_pix), .i_arst_n(arst_n),
        .i_wr_stb(wr_stb), .i_wr_addr(wr_addr), .i_wr_idx(wr_idx), .i_wr_depth(wr_depth),
        .i_clear(clear), .o_wr_busy(wr_busy), .o_ready(ready),
        .o_red(red), .o_green(green), .o_blue(blue),
        .o_hsync(hsync), .o_vsync(vsync), .o_de(de)
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = !clk_pix;
    end

    // x^32 + x^22 + x^2 + x + 1, right shifting
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = galois_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic rgb_t expect_pixel(input int col, input int row);
        rgb_t c;
        if (row < FB_H && col < FB_W) begin
            c = PALETTE[shadow_fb[row * FB_W + col]];
        end else if (row < FB_H && col < 2 * FB_W) begin
            c = '{red: shadow_db[row * FB_W + col - FB_W][11:8], green: 4'h0, blue: 4'h0};
        end else begin
            c = BG_COLOR;
        end
        return c;
    endfunction

    task automatic reset_shadow();
        for (int a = 0; a < BUF_DEPTH; a++) begin
            shadow_fb[a] = FB_CLEAR;
            shadow_db[a] = DB_CLEAR;
        end
    endtask

    // scan position of the pixel on the outputs, and its expected colour
    always @(posedge clk_pix or negedge arst_n) begin : track_scan
        int nc;
        int nr;
        if (!arst_n) begin
            pos_col <= 0;
            pos_row <= 0;
            exp_rgb <= BG_COLOR;
        end else begin
            nc = pos_col;
            nr = pos_row;
            if (!vsync) begin
                nc = 0;
                nr = 0;
            end else if (de) begin
                if (nc == H_ACTIVE - 1) begin
                    nc = 0;
                    nr = nr + 1;
                end else begin
                    nc = nc + 1;
                end
            end
            pos_col <= nc;
            pos_row <= nr;
            exp_rgb <= expect_pixel(nc, nr);
            if (de && check_en) checked_px <= checked_px + 1;
        end
    end

    always @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            de_run   <= 0;
            hs_run   <= 0;
            vs_run   <= 0;
            line_cnt <= 0;
            de_prev  <= 1'b0;
        end else begin
            de_run   <= de ? de_run + 1 : 0;
            hs_run   <= !hsync ? hs_run + 1 : 0;
            vs_run   <= !vsync ? vs_run + 1 : 0;
            de_prev  <= de;
            if (!vsync) line_cnt <= 0;
            else if (de_prev && !de) line_cnt <= line_cnt + 1;
        end
    end

    a_red: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (de && check_en) |-> (red == exp_rgb.red))
        else begin
            pix_errs++;
            $display("** Error at %0t: o_red expected %h, got %h", $time,
                     $sampled(exp_rgb.red), $sampled(red));
        end

    a_green: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (de && check_en) |-> (green == exp_rgb.green))
        else begin
            pix_errs++;
            $display("** Error at %0t: o_green expected %h, got %h", $time,
                     $sampled(exp_rgb.green), $sampled(green));
        end

    a_blue: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (de && check_en) |-> (blue == exp_rgb.blue))
        else begin
            pix_errs++;
            $display("** Error at %0t: o_blue expected %h, got %h", $time,
                     $sampled(exp_rgb.blue), $sampled(blue));
        end

    a_de_len: assert property (@(posedge clk_pix) disable iff (!arst_n)
        $fell(de) |-> (de_run == H_ACTIVE))
        else begin
            sync_errs++;
            $display("** Error at %0t: o_de run expected %0d, got %0d", $time,
                     H_ACTIVE, $sampled(de_run));
        end

    a_hs_len: assert property (@(posedge clk_pix) disable iff (!arst_n)
        $rose(hsync) |-> (hs_run == H_SYNC))
        else begin
            sync_errs++;
            $display("** Error at %0t: o_hsync low run expected %0d, got %0d", $time,
                     H_SYNC, $sampled(hs_run));
        end

    a_lines: assert property (@(posedge clk_pix) disable iff (!arst_n)
        $fell(vsync) |-> (line_cnt == V_ACTIVE))
        else begin
            sync_errs++;
            $display("** Error at %0t: o_de lines expected %0d, got %0d", $time,
                     V_ACTIVE, $sampled(line_cnt));
        end

    a_vs_len: assert property (@(posedge clk_pix) disable iff (!arst_n)
        $rose(vsync) |-> (vs_run == V_SYNC * H_TOTAL))
        else begin
            sync_errs++;
            $display("** Error at %0t: o_vsync low run expected %0d, got %0d", $time,
                     V_SYNC * H_TOTAL, $sampled(vs_run));
        end

    task automatic next_cycle();
        @(posedge clk_pix);
        #1;
    endtask

    task automatic wait_vsync(input logic level);
        do next_cycle(); while (vsync != level);
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!ready && n < limit) begin
            next_cycle();
            n++;
        end
        if (!ready) begin
            misc_errs++;
            $display("o_ready stayed low for %0d cycles after a clear", limit);
        end
    endtask

    // one strobe, only while the holding register is free
    task automatic random_write();
        logic loaded;
        while (wr_busy) next_cycle();
        wr_stb   = 1'b1;
        wr_addr  = BUF_ADDR_W'(rand_bits(BUF_ADDR_W) % BUF_DEPTH);
        wr_idx   = color_idx_t'(rand_bits(4));
        wr_depth = depth_t'(rand_bits(12));
        loaded   = ready;
        if (loaded) begin   // dropped by the DUT otherwise
            shadow_fb[wr_addr] = wr_idx;
            shadow_db[wr_addr] = wr_depth;
        end
        next_cycle();
        wr_stb = 1'b0;
        // a taken write fills the holding register for at least one cycle
        assert (wr_busy == loaded) else begin
            misc_errs++;
            $display("** Error at %0t: o_wr_busy expected %b, got %b", $time,
                     loaded, wr_busy);
        end
    endtask

    task automatic check_frame();
        while (wr_busy) next_cycle();
        wait_vsync(1'b0);
        wait_vsync(1'b1);
        check_en = 1'b1;
        wait_vsync(1'b0);
        check_en = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk_pix);
        $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYC);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        arst_n     = 1'b0;
        wr_stb     = 1'b0;
        wr_addr    = '0;
        wr_idx     = '0;
        wr_depth   = '0;
        clear      = 1'b0;
        check_en   = 1'b0;
        checked_px = 0;
        pix_errs   = 0;
        sync_errs  = 0;
        misc_errs  = 0;
        reset_shadow();
        repeat (3) @(posedge clk_pix);
        #1 arst_n = 1'b1;

        // sweep after reset, then a cleared frame
        assert (!ready) else begin
            misc_errs++;
            $display("** Error at %0t: o_ready expected 0, got %b", $time, ready);
        end
        wait_ready(4 * BUF_DEPTH);
        check_frame();

        // random writes in blanking, then while scan-out owns the port
        repeat (N_WRITES) random_write();
        do next_cycle(); while (!(de && pos_row < FB_H));
        repeat (N_WRITES) random_write();
        check_frame();

        // clear request, writes during the sweep are lost
        clear = 1'b1;
        next_cycle();
        clear = 1'b0;
        assert (!ready) else begin
            misc_errs++;
            $display("** Error at %0t: o_ready expected 0, got %b", $time, ready);
        end
        repeat (8) random_write();
        wait_ready(4 * BUF_DEPTH);
        reset_shadow();
        check_frame();

        if (checked_px != 3 * H_ACTIVE * V_ACTIVE) begin
            misc_errs++;
            $display("only %0d active pixels were compared", checked_px);
        end
        $display("errors: pixel %0d, sync %0d, other %0d", pix_errs, sync_errs, misc_errs);
        if (pix_errs + sync_errs + misc_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tri_display.f ====
verilog/disp_pkg.sv
verilog/px_pkg.sv
verilog/buf_port_if.sv
verilog/display_timing.sv
verilog/pixel_buffer.sv
verilog/buffer_arbiter.sv
verilog/buffer_clear.sv
verilog/scanout.sv
verilog/tri_display.sv
tb/tb_tri_display.sv
